/* verilog/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  localparam int ir_size = 33; // one micro-op word

  // register codes on the 4-bit IR address fields
  localparam logic [3:0] reg_ax   = 4'b0000; // accumulator, AL/AX
  localparam logic [3:0] reg_bx   = 4'b0011;
  localparam logic [3:0] reg_bp   = 4'b0101;
  localparam logic [3:0] reg_si   = 4'b0110;
  localparam logic [3:0] reg_di   = 4'b0111;
  localparam logic [3:0] reg_none = 4'b1100; // no register
  localparam logic [3:0] reg_tmp  = 4'b1101; // scratch for C6/C7

  // low 10 bits of an IR word, decoded per micro-op kind
  typedef union packed {
    struct packed {
      logic [3:0] index;
      logic [3:0] base;
      logic [1:0] seg;
    } mem; // loads and stores
    struct packed {
      logic [5:0] spare;
      logic [3:0] src_reg;
    } rg; // register and immediate moves
  } ir_addr_u;

  typedef enum logic [3:0] {
    st_opcode = 4'd0,
    st_modrm  = 4'd1,
    st_off    = 4'd2,
    st_imm    = 4'd3,
    st_exec0  = 4'd4,
    st_exec1  = 4'd5,
    st_exec2  = 4'd6,
    st_drain  = 4'd7,
    st_idle   = 4'd8
  } fetch_state_e;

endpackage

`default_nettype wire

/* verilog/ea_decode.sv */
`default_nettype none

// 8086 effective address table, rm and mod to base and index
module ea_decode import fetch_pkg::*; (
  input  logic [2:0] rm,
  input  logic [1:0] mod,
  output logic [3:0] base,
  output logic [3:0] index
);

  always_comb begin
    case (rm)
      3'b000: begin base = reg_bx;   index = reg_si;   end // bx+si
      3'b001: begin base = reg_bx;   index = reg_di;   end // bx+di
      3'b010: begin base = reg_bp;   index = reg_si;   end // bp+si
      3'b011: begin base = reg_bp;   index = reg_di;   end // bp+di
      3'b100: begin base = reg_none; index = reg_si;   end
      3'b101: begin base = reg_none; index = reg_di;   end
      3'b110: begin
        // mod 00 here is the direct address, no base at all
        base  = (mod == 2'b00) ? reg_none : reg_bp;
        index = reg_none;
      end
      default: begin base = reg_bx; index = reg_none; end
    endcase
  end

endmodule

`default_nettype wire

/* verilog/op_lookup.sv */
`default_nettype none

// MOV decode table, operand needs and micro-op words
module op_lookup import fetch_pkg::*; #(
  parameter logic [1:0] seg_default = 2'b11
) (
  input  logic [7:0]         opcode,
  input  logic [1:0]         mod,
  input  logic [2:0]         reg_f,
  input  logic [2:0]         rm,
  input  logic [3:0]         base,
  input  logic [3:0]         index,
  input  logic [15:0]        off,
  input  logic [15:0]        imm,
  output logic               need_modrm,
  output logic               need_off,
  output logic               off_size,
  output logic               need_imm,
  output logic               imm_size,
  output logic [1:0]         ninstrs,
  output logic [ir_size-1:0] ir0,
  output logic [ir_size-1:0] ir1,
  output logic [ir_size-1:0] ir2,
  output logic [15:0]        off0,
  output logic [15:0]        off1,
  output logic [15:0]        off2,
  output logic [15:0]        imm0,
  output logic [15:0]        imm1,
  output logic [15:0]        imm2
);

  logic       b;            // byte operation
  logic       d;            // reg field is the destination
  logic [2:0] dst;
  logic [2:0] src;
  logic       direct;       // disp16 only, no base or index
  logic       need_off_mod;
  logic       off_size_mod;
  ir_addr_u   mem_addr;
  ir_addr_u   abs_addr;
  ir_addr_u   reg_addr;
  ir_addr_u   imm_addr;

  // wh and wf stay low for every MOV
  function automatic logic [ir_size-1:0] ir_word(
    input logic       ac,
    input logic       ab,
    input logic       im,
    input logic       ma,
    input logic       by,
    input logic [2:0] fun,
    input logic [2:0] t,
    input logic       wr,
    input logic       wm,
    input logic [3:0] ad_d,
    input logic [3:0] ad_c,
    input ir_addr_u   addr
  );
    ir_word = {ac, ab, im, ma, by, fun, t, 1'b0, wr, wm, 1'b0, ad_d, ad_c, addr};
  endfunction

  assign b   = ~opcode[0];
  assign d   = opcode[1];
  assign dst = d ? reg_f : rm;
  assign src = d ? rm : reg_f;

  assign direct       = (base == reg_none) && (index == reg_none);
  assign need_off_mod = (mod != 2'b11) && (direct || (mod[1] ^ mod[0]));
  assign off_size_mod = direct | mod[1];

  always_comb begin
    mem_addr.mem.index = index;
    mem_addr.mem.base  = base;
    mem_addr.mem.seg   = seg_default;
    abs_addr.mem.index = reg_none;
    abs_addr.mem.base  = reg_none;
    abs_addr.mem.seg   = seg_default;
    reg_addr.rg.spare   = 6'd0;
    reg_addr.rg.src_reg = {1'b0, src};
    imm_addr.rg.spare   = 6'd0;
    imm_addr.rg.src_reg = reg_none; // value comes from imm
  end

  always_comb begin
    need_modrm = 1'b0;
    need_off   = 1'b0;
    off_size   = 1'b0;
    need_imm   = 1'b0;
    imm_size   = 1'b0;
    ninstrs    = 2'd0; // unknown opcode, nothing to run
    ir0  = '0;
    ir1  = '0;
    ir2  = '0;
    off0 = 16'h0000;
    off1 = 16'h0000;
    off2 = 16'h0000;
    imm0 = 16'h0000;
    imm1 = 16'h0000;
    imm2 = 16'h0000;
    casez (opcode)
      8'b1000_10??: begin // mov r/m, r and mov r, r/m
        need_modrm = 1'b1;
        ninstrs    = 2'd1;
        if (mod == 2'b11) begin
          ir0 = ir_word(1'b0, b, 1'b1, 1'b1, b, 3'b001, 3'b001, 1'b1, 1'b0,
                        {1'b0, dst}, 4'h0, reg_addr);
        end else begin
          need_off = need_off_mod;
          off_size = off_size_mod;
          off0     = off;
          if (d)
            ir0 = ir_word(b, 1'b0, 1'b0, 1'b0, b, 3'b000, 3'b111, 1'b1, 1'b0,
                          {1'b0, dst}, 4'h0, mem_addr); // load
          else
            ir0 = ir_word(b, 1'b0, 1'b0, 1'b0, b, 3'b000, 3'b111, 1'b0, 1'b1,
                          4'h0, {1'b0, src}, mem_addr); // store
        end
      end
      8'b1010_00??: begin // accumulator and direct address
        need_off = 1'b1;
        off_size = 1'b1;
        ninstrs  = 2'd1;
        off0     = off;
        if (d)
          ir0 = ir_word(b, 1'b0, 1'b0, 1'b0, b, 3'b000, 3'b111, 1'b0, 1'b1,
                        4'h0, reg_ax, abs_addr);
        else
          ir0 = ir_word(b, 1'b0, 1'b0, 1'b0, b, 3'b000, 3'b111, 1'b1, 1'b0,
                        reg_ax, 4'h0, abs_addr);
      end
      8'b1011_????: begin // mov reg, imm
        need_imm = 1'b1;
        imm_size = opcode[3]; // word form
        ninstrs  = 2'd1;
        imm0     = imm;
        ir0 = ir_word(1'b0, 1'b0, 1'b1, 1'b1, ~opcode[3], 3'b001, 3'b001, 1'b1, 1'b0,
                      {1'b0, opcode[2:0]}, 4'h0, imm_addr);
      end
      8'b1100_011?: begin
        // mov r/m, imm goes through the temporary register
        need_modrm = 1'b1;
        need_off   = need_off_mod;
        off_size   = off_size_mod;
        need_imm   = 1'b1;
        imm_size   = ~b;
        ninstrs    = 2'd2;
        imm0       = imm;
        off1       = off;
        ir0 = ir_word(1'b0, 1'b0, 1'b1, 1'b1, b, 3'b001, 3'b001, 1'b1, 1'b0,
                      reg_tmp, 4'h0, imm_addr);
        ir1 = ir_word(1'b0, 1'b0, 1'b0, 1'b0, b, 3'b000, 3'b111, 1'b0, 1'b1,
                      4'h0, reg_tmp, mem_addr);
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/fetch.sv */
`default_nettype none

module fetch import fetch_pkg::*; #(
  parameter logic [1:0] seg_default = 2'b11
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [15:0]        cs,
  input  logic [15:0]        data,
  output logic [19:0]        pc,
  output logic               bytefetch,
  output logic               executing,
  output logic [ir_size-1:0] ir,
  output logic [15:0]        off,
  output logic [15:0]        imm
);

  fetch_state_e       state;
  fetch_state_e       state_nx;
  fetch_state_e       exec_first;
  logic [15:0]        ip;
  logic [7:0]         opcode_r;
  logic [7:0]         modrm_r;
  logic [7:0]         opcode;
  logic [7:0]         modrm;
  logic [15:0]        off_m;
  logic [15:0]        imm_m;
  logic [1:0]         mod;
  logic [2:0]         reg_f;
  logic [2:0]         rm;
  logic [3:0]         base;
  logic [3:0]         index;
  logic               need_modrm;
  logic               need_off;
  logic               off_size;
  logic               need_imm;
  logic               imm_size;
  logic [1:0]         ninstrs;
  logic [ir_size-1:0] ir0;
  logic [ir_size-1:0] ir1;
  logic [ir_size-1:0] ir2;
  logic [15:0]        off0;
  logic [15:0]        off1;
  logic [15:0]        off2;
  logic [15:0]        imm0;
  logic [15:0]        imm1;
  logic [15:0]        imm2;

  op_lookup #(.seg_default(seg_default)) u_op_lookup (
    .opcode(opcode), .mod(mod), .reg_f(reg_f), .rm(rm),
    .base(base), .index(index), .off(off_m), .imm(imm_m),
    .need_modrm(need_modrm), .need_off(need_off), .off_size(off_size),
    .need_imm(need_imm), .imm_size(imm_size), .ninstrs(ninstrs),
    .ir0(ir0), .ir1(ir1), .ir2(ir2),
    .off0(off0), .off1(off1), .off2(off2),
    .imm0(imm0), .imm1(imm1), .imm2(imm2)
  );

  ea_decode u_ea_decode (.rm(rm), .mod(mod), .base(base), .index(index));

  // opcode and modrm bytes are decoded live in the cycle they arrive
  assign opcode = (state == st_opcode) ? data[7:0] : opcode_r;
  assign modrm  = (state == st_modrm) ? data[7:0] : modrm_r;
  assign mod    = modrm[7:6];
  assign reg_f  = modrm[5:3];
  assign rm     = modrm[2:0];

  assign pc         = {cs, 4'h0} + {4'h0, ip};
  assign bytefetch  = (state == st_off) ? ~off_size :
                      (state == st_imm) ? ~imm_size : 1'b1;
  assign executing  = state inside {st_exec0, st_exec1, st_exec2, st_drain};
  assign exec_first = (ninstrs == 2'd0) ? st_drain : st_exec0;

  always_comb begin
    state_nx = st_idle;
    case (state)
      st_opcode:
        if (need_modrm)    state_nx = st_modrm;
        else if (need_off) state_nx = st_off;
        else if (need_imm) state_nx = st_imm;
        else               state_nx = exec_first;
      st_modrm:
        if (need_off)      state_nx = st_off;
        else if (need_imm) state_nx = st_imm;
        else               state_nx = exec_first;
      st_off:   state_nx = need_imm ? st_imm : exec_first;
      st_imm:   state_nx = exec_first;
      st_exec0: state_nx = (ninstrs > 2'd1) ? st_exec1 : st_drain;
      st_exec1: state_nx = (ninstrs > 2'd2) ? st_exec2 : st_drain;
      st_exec2: state_nx = st_drain;
      st_drain: state_nx = st_idle;
      default:  state_nx = st_opcode; // idle
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      ip    <= 16'h0000;
      ir    <= '0;
      off   <= 16'h0000;
      imm   <= 16'h0000;
    end else begin
      state <= state_nx;
      ir    <= '0; // only exec states load a word
      off   <= 16'h0000;
      imm   <= 16'h0000;
      case (state)
        st_opcode, st_modrm: ip <= ip + 16'd1;
        st_off: ip <= ip + 16'd1 + {15'd0, off_size};
        st_imm: ip <= ip + 16'd1 + {15'd0, imm_size};
        st_exec0: begin
          ir  <= ir0;
          off <= off0;
          imm <= imm0;
        end
        st_exec1: begin
          ir  <= ir1;
          off <= off1;
          imm <= imm1;
        end
        st_exec2: begin
          ir  <= ir2;
          off <= off2;
          imm <= imm2;
        end
        default: ;
      endcase
    end
  end

  // instruction bytes and operands
  always_ff @(posedge clk) begin
    case (state)
      st_opcode: begin
        opcode_r <= data[7:0];
        off_m    <= 16'h0000; // mod 00 has no displacement
        imm_m    <= 16'h0000;
      end
      st_modrm: modrm_r <= data[7:0];
      st_off:   off_m <= off_size ? data : {{8{data[7]}}, data[7:0]}; // disp8 sign extended
      st_imm:   imm_m <= imm_size ? data : {8'h00, data[7:0]};
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/front_end.sv */
`default_nettype none

// fetch and decode front end, MOV family only
module front_end import fetch_pkg::*; #(
  parameter logic [1:0] seg_default = 2'b11 // data segment
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [15:0]        cs,
  input  logic [15:0]        data,
  output logic [19:0]        pc,
  output logic               bytefetch,
  output logic               executing,
  output logic [ir_size-1:0] ir,
  output logic [15:0]        off,
  output logic [15:0]        imm
);

  fetch #(.seg_default(seg_default)) u_fetch (
    .clk       (clk),
    .rst       (rst),
    .cs        (cs),
    .data      (data),
    .pc        (pc),
    .bytefetch (bytefetch),
    .executing (executing),
    .ir        (ir),
    .off       (off),
    .imm       (imm)
  );

endmodule

`default_nettype wire

/* verification/front_end_sva.sv */
`default_nettype none

// checks on the fetch state machine and its registered IR outputs
module front_end_sva import fetch_pkg::*; (
  input logic               clk,
  input logic               rst,
  input fetch_state_e       state,
  input logic [ir_size-1:0] ir,
  input logic [15:0]        off,
  input logic [15:0]        imm
);

  // a word only appears right after an exec state
  word_after_exec: assert property (@(posedge clk) disable iff (rst)
    (ir != '0) |-> ($past(state) inside {st_exec0, st_exec1, st_exec2}))
    else $error("ir is non-zero without an exec state in the cycle before");

  state_legal: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(state) && (state inside {st_opcode, st_modrm, st_off, st_imm,
      st_exec0, st_exec1, st_exec2, st_drain, st_idle}))
    else $error("fetch state holds an illegal code");

  reset_clears: assert property (@(posedge clk)
    rst |=> (ir == '0 && off == 16'h0000 && imm == 16'h0000))
    else $error("ir, off or imm not cleared after reset");

endmodule

`default_nettype wire

/* verification/front_end_tb.sv */
`default_nettype none

module front_end_tb import fetch_pkg::*;;

  localparam logic [15:0] cs_val    = 16'h0240;
  localparam logic [1:0]  seg_code  = 2'b10;   // data segment code for this run
  localparam int          code_base = 'h2400;  // cs_val * 16
  localparam int          n_instr   = 42;
  localparam int          max_wait  = 4000;

  logic               clk;
  logic               rst;
  logic [15:0]        cs;
  logic [15:0]        data;
  logic [19:0]        pc;
  logic               bytefetch;
  logic               executing;
  logic [ir_size-1:0] ir;
  logic [15:0]        off;
  logic [15:0]        imm;

  logic [7:0]         mem [0:65535];
  integer             seed;
  int                 errors;
  int                 wp;      // program write pointer
  logic               checking;
  logic               done;
  int                 ci;
  int                 wi;

  // per cycle, counted from the first opcode fetch
  logic [19:0]        cyc_pc [$];
  logic               cyc_bf [$];
  logic               cyc_ex [$];
  logic               cyc_word [$];
  int                 cyc_kind [$];
  // IR words in the order they should come out
  logic [ir_size-1:0] exp_ir [$];
  logic [15:0]        exp_off [$];
  logic [15:0]        exp_imm [$];

  front_end #(.seg_default(seg_code)) dut (
    .clk       (clk),
    .rst       (rst),
    .cs        (cs),
    .data      (data),
    .pc        (pc),
    .bytefetch (bytefetch),
    .executing (executing),
    .ir        (ir),
    .off       (off),
    .imm       (imm)
  );

  bind fetch front_end_sva u_sva (
    .clk(clk), .rst(rst), .state(state), .ir(ir), .off(off), .imm(imm)
  );

  always #20 clk = ~clk;

  assign data = {mem[pc[15:0] + 16'd1], mem[pc[15:0]]}; // little endian word at pc

  function automatic string kind_name(input int kind);
    case (kind)
      0: return "mov_reg_reg";
      1: return "mov_modrm_mem";
      2: return "mov_acc_direct";
      3: return "mov_reg_imm";
      4: return "mov_mem_imm";
      5: return "unknown_opcode";
      default: return "mov_direct_addr";
    endcase
  endfunction

  function automatic logic [7:0] byte_at(input int ip_a);
    return mem[(code_base + ip_a) & 'hffff];
  endfunction

  // register target, source in the register view
  function automatic logic [ir_size-1:0] move_word(input logic ab, by,
                                                   input logic [3:0] dest, src_r);
    return {1'b0, ab, 2'b11, by, 3'b001, 3'b001, 4'b0100, dest, 4'h0, 6'd0, src_r};
  endfunction

  // load or store, memory view of the address field
  function automatic logic [ir_size-1:0] mem_word(input logic ac, by, store,
                                                  input logic [3:0] r, ix, bs);
    logic [3:0] dest;
    logic [3:0] src_r;
    dest  = store ? 4'h0 : r;
    src_r = store ? r : 4'h0;
    return {ac, 3'b000, by, 3'b000, 3'b111, 1'b0, ~store, store, 1'b0, dest, src_r,
            ix, bs, seg_code};
  endfunction

  // reference decoder for the instruction at ip a
  function automatic void ref_decode(input int a, output int len, output int n,
                                     output logic has_m, has_o, o_word, has_i, i_word,
                                     output logic [ir_size-1:0] w0, w1,
                                     output logic [15:0] o0, i0, o1, i1);
    logic [7:0]  op;
    logic [7:0]  lo;
    logic [1:0]  md;
    logic [2:0]  rg;
    logic [2:0]  r;
    logic        b;
    logic        d;
    logic [3:0]  bs;
    logic [3:0]  ix;
    logic [15:0] ofs;
    logic [15:0] iv;
    int          p;
    op = byte_at(a);
    {md, rg, r} = byte_at(a + 1);
    b = ~op[0];
    d = op[1];
    n = 0;
    has_o = 1'b0;
    o_word = 1'b0;
    has_i = 1'b0;
    i_word = 1'b0;
    w0 = '0;
    w1 = '0;
    {o0, i0, o1, i1} = '0;
    has_m = (op[7:2] == 6'b100010) || (op[7:1] == 7'b1100011);
    if (op[7:2] == 6'b101000) begin
      has_o  = 1'b1;
      o_word = 1'b1;
    end else if (has_m && md != 2'b11) begin
      has_o  = (md != 2'b00) || (r == 3'b110); // mod 00 rm 110 is disp16
      o_word = (md != 2'b01);
    end
    if (op[7:4] == 4'hb) begin
      has_i  = 1'b1;
      i_word = op[3];
    end else if (op[7:1] == 7'b1100011) begin
      has_i  = 1'b1;
      i_word = op[0];
    end
    p = a + 1 + has_m;
    ofs = 16'h0000;
    if (has_o) begin
      lo  = byte_at(p);
      ofs = o_word ? {byte_at(p + 1), lo} : {{8{lo[7]}}, lo};
      p   = p + 1 + o_word;
    end
    iv = 16'h0000;
    if (has_i) begin
      lo = byte_at(p);
      iv = i_word ? {byte_at(p + 1), lo} : {8'h00, lo};
      p  = p + 1 + i_word;
    end
    len = p - a;
    case (r)
      3'd0, 3'd1: bs = reg_bx;
      3'd2, 3'd3: bs = reg_bp;
      3'd6:       bs = (md == 2'b00) ? reg_none : reg_bp;
      3'd7:       bs = reg_bx;
      default:    bs = reg_none;
    endcase
    case (r)
      3'd0, 3'd2, 3'd4: ix = reg_si;
      3'd1, 3'd3, 3'd5: ix = reg_di;
      default:          ix = reg_none;
    endcase
    if (op[7:2] == 6'b100010) begin
      n = 1;
      if (md == 2'b11) begin
        w0 = move_word(b, b, {1'b0, (d ? rg : r)}, {1'b0, (d ? r : rg)});
      end else begin
        w0 = mem_word(b, b, ~d, {1'b0, rg}, ix, bs);
        o0 = ofs;
      end
    end else if (op[7:2] == 6'b101000) begin
      n  = 1;
      w0 = mem_word(b, b, d, reg_ax, reg_none, reg_none); // A2/A3 store
      o0 = ofs;
    end else if (op[7:4] == 4'hb) begin
      n  = 1;
      w0 = move_word(1'b0, ~op[3], {1'b0, op[2:0]}, reg_none);
      i0 = iv;
    end else if (op[7:1] == 7'b1100011) begin
      n  = 2; // immediate into tmp, then store tmp
      w0 = move_word(1'b0, b, reg_tmp, reg_none);
      i0 = iv;
      w1 = mem_word(1'b0, b, 1'b1, reg_tmp, ix, bs);
      o1 = ofs;
    end
  endfunction

  task automatic add_cycle(input int a, input logic bf, ex, word, input int kind);
    cyc_pc.push_back(code_base + a);
    cyc_bf.push_back(bf);
    cyc_ex.push_back(ex);
    cyc_word.push_back(word);
    cyc_kind.push_back(kind);
  endtask

  // cycle by cycle expectation for one instruction
  task automatic expect_instr(input int a, input int kind, output int len);
    int                 n;
    int                 q;
    logic               has_m;
    logic               has_o;
    logic               o_word;
    logic               has_i;
    logic               i_word;
    logic [ir_size-1:0] w0;
    logic [ir_size-1:0] w1;
    logic [15:0]        o0;
    logic [15:0]        i0;
    logic [15:0]        o1;
    logic [15:0]        i1;
    ref_decode(a, len, n, has_m, has_o, o_word, has_i, i_word, w0, w1, o0, i0, o1, i1);
    q = a + 1;
    add_cycle(a, 1'b1, 1'b0, 1'b0, kind);
    if (has_m) begin
      add_cycle(q, 1'b1, 1'b0, 1'b0, kind);
      q = q + 1;
    end
    if (has_o) begin
      add_cycle(q, ~o_word, 1'b0, 1'b0, kind);
      q = q + 1 + o_word;
    end
    if (has_i)
      add_cycle(q, ~i_word, 1'b0, 1'b0, kind);
    for (int k = 0; k < n; k++)
      add_cycle(a + len, 1'b1, 1'b1, k > 0, kind); // exec k shows word k-1
    add_cycle(a + len, 1'b1, 1'b1, n > 0, kind);   // drain
    add_cycle(a + len, 1'b1, 1'b0, 1'b0, kind);    // idle
    if (n > 0) begin
      exp_ir.push_back(w0);
      exp_off.push_back(o0);
      exp_imm.push_back(i0);
    end
    if (n > 1) begin
      exp_ir.push_back(w1);
      exp_off.push_back(o1);
      exp_imm.push_back(i1);
    end
  endtask

  task automatic emit(input logic [7:0] v);
    mem[code_base + wp] = v;
    wp++;
  endtask

  task automatic emit_disp(input logic [1:0] md, input logic [2:0] r);
    logic [31:0] v;
    v = $random(seed);
    if (md == 2'b01) begin
      emit(v[7:0]);
    end else if (md == 2'b10 || (md == 2'b00 && r == 3'b110)) begin
      emit(v[7:0]);
      emit(v[15:8]);
    end
  endtask

  task automatic report_mismatch(input string name, input string field,
                                 input logic [63:0] e, input logic [63:0] a);
    $display("ERROR %s %s: expected %0h, actual %0h", name, field, e, a);
    errors++;
  endtask

  // comparison, sampled away from the rising edge
  always @(negedge clk) begin
    if (checking && !done) begin
      if (pc !== cyc_pc[ci])
        report_mismatch(kind_name(cyc_kind[ci]), "pc", cyc_pc[ci], pc);
      if (bytefetch !== cyc_bf[ci])
        report_mismatch(kind_name(cyc_kind[ci]), "bytefetch", cyc_bf[ci], bytefetch);
      if (executing !== cyc_ex[ci])
        report_mismatch(kind_name(cyc_kind[ci]), "executing", cyc_ex[ci], executing);
      if ((ir !== '0) !== cyc_word[ci]) begin
        report_mismatch(kind_name(cyc_kind[ci]), "ir_valid", cyc_word[ci], ir !== '0);
      end else if (cyc_word[ci]) begin
        if (ir !== exp_ir[wi])
          report_mismatch(kind_name(cyc_kind[ci]), "ir", exp_ir[wi], ir);
        if (off !== exp_off[wi])
          report_mismatch(kind_name(cyc_kind[ci]), "off", exp_off[wi], off);
        if (imm !== exp_imm[wi])
          report_mismatch(kind_name(cyc_kind[ci]), "imm", exp_imm[wi], imm);
        wi++;
      end
      ci++;
      if (ci == cyc_pc.size())
        done = 1'b1;
    end
  end

  initial begin : main
    int          i;
    int          kind;
    int          a;
    int          len;
    int          waited;
    int          kinds [$];
    logic [31:0] rv;
    logic [1:0]  md;
    logic [7:0]  op;
    clk = 1'b0;
    rst = 1'b1;
    cs = cs_val;
    seed = 22;
    errors = 0;
    checking = 1'b0;
    done = 1'b0;
    ci = 0;
    wi = 0;
    wp = 0;
    for (i = 0; i < 65536; i++)
      mem[i] = i[7:0] ^ i[15:8];
    for (i = 0; i < n_instr; i++) begin
      rv = $random(seed);
      md = (rv[9:8] == 2'b11) ? 2'b10 : rv[9:8]; // memory forms only
      kind = i % 7;
      kinds.push_back(kind);
      case (kind)
        0: begin
          emit(8'h88 | rv[1:0]);
          emit({2'b11, rv[7:2]});
        end
        1: begin
          emit(8'h88 | rv[1:0]);
          emit({md, rv[7:2]});
          emit_disp(md, rv[4:2]);
        end
        2: begin
          emit(8'ha0 | rv[1:0]);
          emit(rv[15:8]);
          emit(rv[23:16]);
        end
        3: begin
          op = 8'hb0 | rv[3:0];
          emit(op);
          emit(rv[15:8]);
          if (op[3])
            emit(rv[23:16]);
        end
        4: begin
          op = 8'hc6 | rv[0];
          emit(op);
          emit({md, 3'b000, rv[4:2]});
          emit_disp(md, rv[4:2]);
          emit(rv[15:8]);
          if (op[0])
            emit(rv[23:16]);
        end
        5: emit(rv[0] ? 8'h90 : 8'hf4); // outside the MOV family
        default: begin
          emit(8'h8a | rv[0]);
          emit({2'b00, rv[7:5], 3'b110}); // direct address
          emit_disp(2'b00, 3'b110);
        end
      endcase
    end
    a = 0;
    for (i = 0; i < n_instr; i++) begin
      expect_instr(a, kinds[i], len);
      a = a + len;
    end

    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (ir !== '0)
      report_mismatch("reset", "ir", 64'd0, ir);
    if (off !== 16'h0000)
      report_mismatch("reset", "off", 64'd0, off);
    if (imm !== 16'h0000)
      report_mismatch("reset", "imm", 64'd0, imm);
    if (pc !== code_base)
      report_mismatch("reset", "pc", code_base, pc);
    @(posedge clk);
    checking = 1'b1; // this cycle fetches the first opcode

    waited = 0;
    while (!done && waited < max_wait) begin
      @(posedge clk);
      waited++;
    end
    if (!done) begin
      $display("timeout: only %0d of %0d expected cycles were checked", ci, cyc_pc.size());
      errors++;
    end
    $display("checked %0d cycles and %0d IR words, errors: %0d", ci, wi, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
verilog/fetch_pkg.sv
verilog/ea_decode.sv
verilog/op_lookup.sv
verilog/fetch.sv
verilog/front_end.sv
verification/front_end_sva.sv
verification/front_end_tb.sv
